// ==== noc_vc_link.f ====
+incdir+bench
src/noc_vc_pkg.sv
src/noc_flit_fifo.sv
src/noc_rr_arbiter.sv
src/noc_vc_mux.sv
src/noc_vc_link.sv
bench/noc_vc_link_tb.sv

// ==== Bender.yml ====
package:
  name: noc_vc_link

sources:
  - files:
      - src/noc_vc_pkg.sv
      - src/noc_flit_fifo.sv
      - src/noc_rr_arbiter.sv
      - src/noc_vc_mux.sv
      - src/noc_vc_link.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/noc_vc_link_tb.sv

// ==== bench/noc_vc_link_model.svh ====
// Reference model for the VC link testbench.
// Expected-flit queues tagged by VC, the in-order compare on each output
// transfer, and the wait counters behind the fairness check.

`ifndef NOC_VC_LINK_MODEL_SVH
`define NOC_VC_LINK_MODEL_SVH

int    exp_vc_q[$]; // VC of every flit inside the link, oldest first.
flit_t exp_flit_q[$]; // payload of every flit inside the link.
logic  exp_last_q[$]; // last flag of every flit inside the link.
int    wait_cnt[NUM_VC]; // other-VC deliveries since this VC's own last one.
logic  fair_on; // fairness bookkeeping runs only while this is set.
int    err_cnt; // wrong values and failed checks so far.

// wrong value seen, printed with the time.
task automatic report_error(input string msg);
  $display("ERR %0t: %s", $time, msg);
  err_cnt++;
endtask

// number of flits of one VC still inside the link.
function automatic int pending(input int vc);
  int n;
  n = 0;
  foreach (exp_vc_q[i]) begin
    if (exp_vc_q[i] == vc) n++;
  end
  return n;
endfunction

// called on every input transfer.
task automatic expect_flit(input int vc, input flit_t flit, input logic last);
  exp_vc_q.push_back(vc);
  exp_flit_q.push_back(flit);
  exp_last_q.push_back(last);
endtask

// called on every output transfer, compares against the oldest flit of that VC.
task automatic check_flit(input int vc, input flit_t flit, input logic last);
  int idx;
  int i;
  int v;
  idx = -1;
  for (i = exp_vc_q.size() - 1; i >= 0; i--) begin
    if (exp_vc_q[i] == vc) idx = i; // ends on the oldest entry of this VC.
  end
  if (idx < 0) begin
    report_error($sformatf("vc %0d delivered flit %h with none expected", vc, flit));
  end else begin
    if (exp_flit_q[idx] !== flit) begin
      report_error($sformatf("vc %0d flit %h, expected %h", vc, flit, exp_flit_q[idx]));
    end
    if (exp_last_q[idx] !== last) begin
      report_error($sformatf("vc %0d last %b, expected %b", vc, last, exp_last_q[idx]));
    end
    exp_vc_q.delete(idx);
    exp_flit_q.delete(idx);
    exp_last_q.delete(idx);
  end
  if (fair_on) begin
    wait_cnt[vc] = 0; // this VC was just served.
    for (v = 0; v < NUM_VC; v++) begin
      if (v != vc && pending(v) > 0) begin
        wait_cnt[v]++; // a loaded VC watched another one go first.
        if (wait_cnt[v] > NUM_VC) begin
          report_error($sformatf("vc %0d waited %0d transfers", v, wait_cnt[v]));
        end
      end
    end
  end
endtask

`endif

// ==== bench/noc_vc_link_tb.sv ====
// Testbench for the VC link segment.
// Clock, reset, random per-VC traffic with random back-pressure,
// output checks against the included model, timeout and summary.

`timescale 1ns/1ps
`default_nettype none

module noc_vc_link_tb import noc_vc_pkg::*; ();

  localparam int unsigned SEED = 32'hac7b59f9;
  localparam int T2_FLITS = 40; // VC 0 only.
  localparam int T3_FLITS = 60; // per VC.
  localparam int T4_FLITS = 30; // per VC.
  localparam int T5_FLITS = 50; // per VC.
  localparam int TOTAL_FLITS = T2_FLITS + NUM_VC * (T3_FLITS + T4_FLITS + T5_FLITS);
  localparam int MAX_CYCLES = 20 * TOTAL_FLITS + 200;

  logic               clk;
  logic               rst;
  flit_t [NUM_VC-1:0] in_flit;
  vc_mask_t           in_last;
  vc_mask_t           in_valid;
  vc_mask_t           in_ready;
  flit_t [NUM_VC-1:0] out_flit;
  vc_mask_t           out_last;
  vc_mask_t           out_valid;
  vc_mask_t           out_ready;

  `include "noc_vc_link_model.svh"

  vc_mask_t    in_fire; // input transfers at the coming edge, sampled at negedge.
  int          to_send[NUM_VC]; // flits still to be offered per VC.
  int          ready_pct[NUM_VC]; // chance of out_ready per cycle, in percent.
  int          in_cnt[NUM_VC]; // accepted input flits per VC in the running test.
  int          out_cnt[NUM_VC]; // deliveries per VC in the running test.
  int          valid_pct; // chance of offering a new flit per cycle.
  int          cycle_cnt = 0;
  int          pass_cnt;
  int          fail_cnt;
  int          errs_before;
  int          vc0_after_block; // VC 0 deliveries once VC 1 was blocked.
  logic        watch_block; // back-pressure test is running.
  logic        blocked_seen; // in_ready[1] was seen low.
  int unsigned seed_val;

  noc_vc_link i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (in_flit),
    .in_last   (in_last),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #50 clk = ~clk; // 100 ns period.

  //////////////////////////////
  // monitor and timeout
  //////////////////////////////

  // inputs change 1 ns after the rising edge, so the negedge sees settled values.
  always @(negedge clk) begin
    int c;
    in_fire = '0;
    if (!rst) begin
      for (c = 0; c < NUM_VC; c++) begin
        in_fire[c] = in_valid[c] & in_ready[c];
        if (in_fire[c]) begin
          expect_flit(c, in_flit[c], in_last[c]);
          in_cnt[c]++;
        end
        if (out_valid[c] && out_ready[c]) begin
          check_flit(c, out_flit[c], out_last[c]);
          out_cnt[c]++;
          if (watch_block && blocked_seen && c == 0) vc0_after_block++;
        end
      end
      if (watch_block && !in_ready[1]) blocked_seen = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("timeout after %0d cycles, flits stopped coming out of the link", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // one clock of traffic; a raised valid holds until its transfer.
  task automatic step_cycle();
    int c;
    @(posedge clk);
    #1;
    for (c = 0; c < NUM_VC; c++) begin
      if (in_valid[c] && !in_fire[c]) begin
        in_valid[c] = 1'b1; // flit and last stay as they are.
      end else if (to_send[c] > 0 && $urandom_range(99) < valid_pct) begin
        in_valid[c] = 1'b1;
        in_flit[c]  = {$urandom, $urandom};
        in_last[c]  = $urandom_range(1);
        to_send[c]--;
      end else begin
        in_valid[c] = 1'b0;
      end
      out_ready[c] = ($urandom_range(99) < ready_pct[c]);
    end
  endtask

  // runs until every accepted flit has come out of its own output.
  task automatic run_until_drained();
    logic busy;
    int   c;
    busy = 1'b1;
    while (busy) begin
      step_cycle();
      busy = (in_valid != '0);
      for (c = 0; c < NUM_VC; c++) begin
        if (to_send[c] != 0 || out_cnt[c] < in_cnt[c]) busy = 1'b1;
      end
    end
  endtask

  task automatic start_test(input int n0, input int n1, input int vpct, input int r0,
                            input int r1);
    to_send[0]   = n0;
    to_send[1]   = n1;
    valid_pct    = vpct;
    ready_pct[0] = r0;
    ready_pct[1] = r1;
    in_cnt[0]    = 0;
    in_cnt[1]    = 0;
    out_cnt[0]   = 0;
    out_cnt[1]   = 0;
    errs_before  = err_cnt;
  endtask

  // failure that is not a wrong value.
  task automatic note_failure(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic end_test(input int num, input string name);
    if (exp_vc_q.size() != 0) begin
      note_failure($sformatf("test %0d left %0d flits undelivered", num, exp_vc_q.size()));
    end
    if (err_cnt == errs_before) begin
      $display("test %0d %s: pass", num, name);
      pass_cnt++;
    end else begin
      $display("test %0d %s: FAIL with %0d errors", num, name, err_cnt - errs_before);
      fail_cnt++;
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    seed_val    = $urandom(SEED); // the one seeding of the run.
    clk         = 1'b0;
    rst         = 1'b1;
    in_flit     = '0;
    in_last     = '0;
    in_valid    = '0;
    out_ready   = '1;
    in_fire     = '0;
    err_cnt     = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    fair_on     = 1'b0;
    watch_block = 1'b0;
    wait_cnt    = '{default: 0};
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // state right after reset.
    start_test(0, 0, 0, 100, 100);
    if (out_valid !== '0) report_error($sformatf("out_valid %b after reset", out_valid));
    if (in_ready !== '1) report_error($sformatf("in_ready %b after reset", in_ready));
    end_test(1, "reset state");

    start_test(T2_FLITS, 0, 70, 100, 100);
    run_until_drained();
    if (out_cnt[0] != T2_FLITS) report_error($sformatf("vc 0 delivered %0d", out_cnt[0]));
    if (out_cnt[1] != 0) report_error($sformatf("idle vc 1 delivered %0d", out_cnt[1]));
    end_test(2, "single vc");

    start_test(T3_FLITS, T3_FLITS, 60, 50, 50);
    run_until_drained();
    if (out_cnt[0] != T3_FLITS) report_error($sformatf("vc 0 delivered %0d", out_cnt[0]));
    if (out_cnt[1] != T3_FLITS) report_error($sformatf("vc 1 delivered %0d", out_cnt[1]));
    end_test(3, "mixed traffic");

    // VC 1 is stalled at the output while VC 0 streams through.
    start_test(T4_FLITS, T4_FLITS, 100, 100, 0);
    blocked_seen    = 1'b0;
    vc0_after_block = 0;
    watch_block     = 1'b1;
    while (out_cnt[0] < T4_FLITS) step_cycle();
    watch_block = 1'b0;
    if (!blocked_seen) note_failure("test 4: in_ready[1] never dropped under back-pressure");
    if (vc0_after_block == 0) note_failure("test 4: vc 0 stopped while vc 1 was blocked");
    ready_pct[1] = 100; // release VC 1.
    run_until_drained();
    if (out_cnt[1] != T4_FLITS) report_error($sformatf("vc 1 delivered %0d", out_cnt[1]));
    end_test(4, "back-pressure isolation");

    start_test(T5_FLITS, T5_FLITS, 100, 100, 100);
    wait_cnt = '{default: 0};
    fair_on  = 1'b1;
    run_until_drained();
    fair_on = 1'b0;
    if (out_cnt[0] != T5_FLITS) report_error($sformatf("vc 0 delivered %0d", out_cnt[0]));
    if (out_cnt[1] != T5_FLITS) report_error($sformatf("vc 1 delivered %0d", out_cnt[1]));
    end_test(5, "fairness");

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/noc_vc_link.sv ====
// Top level of the virtual-channel link segment.
// Input FIFO per VC, the VC multiplexer onto the shared flit path,
// and an output FIFO per VC fed from that path.
// Flit order and last flags are kept within each VC.

`timescale 1ns/1ps
`default_nettype none

module noc_vc_link import noc_vc_pkg::*; (
  input  wire                   clk,
  input  wire                   rst,

  input  flit_t [NUM_VC-1:0]    in_flit,
  input  vc_mask_t              in_last,
  input  vc_mask_t              in_valid,
  output vc_mask_t              in_ready,

  output flit_t [NUM_VC-1:0]    out_flit,
  output vc_mask_t              out_last,
  output vc_mask_t              out_valid,
  input  vc_mask_t              out_ready
);

  //////////////////////////////
  // internal nets
  //////////////////////////////

  flit_t [NUM_VC-1:0] mux_in_flit; // input FIFO heads towards the multiplexer.
  vc_mask_t           mux_in_last; // last flags of those heads.
  vc_mask_t           mux_in_valid; // input FIFO not empty.
  vc_mask_t           mux_in_ready; // multiplexer takes from that VC.

  flit_t              shared_flit; // the one flit crossing the link this cycle.
  logic               shared_last; // its last flag.
  vc_mask_t           mux_out_valid; // which output FIFO should take the shared flit.
  vc_mask_t           mux_out_ready; // output FIFO has room.

  //////////////////////////////
  // input side
  //////////////////////////////

  for (genvar c = 0; c < NUM_VC; c++) begin : g_in_fifo
    noc_flit_fifo i_in_fifo (
      .clk        (clk),
      .rst        (rst),
      .push_flit  (in_flit[c]),
      .push_last  (in_last[c]),
      .push_valid (in_valid[c]),
      .push_ready (in_ready[c]),
      .pop_flit   (mux_in_flit[c]),
      .pop_last   (mux_in_last[c]),
      .pop_valid  (mux_in_valid[c]),
      .pop_ready  (mux_in_ready[c])
    );
  end

  //////////////////////////////
  // shared path
  //////////////////////////////

  noc_vc_mux i_mux (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (mux_in_flit),
    .in_last   (mux_in_last),
    .in_valid  (mux_in_valid),
    .in_ready  (mux_in_ready),
    .out_flit  (shared_flit),
    .out_last  (shared_last),
    .out_valid (mux_out_valid),
    .out_ready (mux_out_ready)
  );

  //////////////////////////////
  // output side
  //////////////////////////////

  // every output FIFO sees the shared flit, only the selected one gets valid.
  for (genvar c = 0; c < NUM_VC; c++) begin : g_out_fifo
    noc_flit_fifo i_out_fifo (
      .clk        (clk),
      .rst        (rst),
      .push_flit  (shared_flit),
      .push_last  (shared_last),
      .push_valid (mux_out_valid[c]),
      .push_ready (mux_out_ready[c]),
      .pop_flit   (out_flit[c]),
      .pop_last   (out_last[c]),
      .pop_valid  (out_valid[c]),
      .pop_ready  (out_ready[c])
    );
  end

endmodule

`default_nettype wire

// ==== src/noc_vc_mux.sv ====
// Virtual-channel multiplexer onto one shared flit path.
// A registered one-hot selection picks the VC that may cross the path.
// Data, valid and ready pass through combinationally, gated per VC by
// the selection, while the round-robin arbiter chooses the next VC.

`timescale 1ns/1ps
`default_nettype none

module noc_vc_mux import noc_vc_pkg::*; (
  input  wire                   clk,
  input  wire                   rst,

  input  flit_t [NUM_VC-1:0]    in_flit,
  input  vc_mask_t              in_last,
  input  vc_mask_t              in_valid,
  output vc_mask_t              in_ready,

  output flit_t                 out_flit,
  output logic                  out_last,
  output vc_mask_t              out_valid,
  input  vc_mask_t              out_ready
);

  //////////////////////////////
  // selection state
  //////////////////////////////

  vc_mask_t sel; // one-hot, the VC that owns the shared path this cycle.
  vc_mask_t nxt_sel; // arbiter's choice for the next cycle.
  vc_mask_t req; // channels with a flit waiting and room downstream.

  assign req = in_valid & out_ready; // only channels that could move a flit compete.

  //////////////////////////////
  // per-VC gating
  //////////////////////////////

  assign out_valid = in_valid & sel; // only the selected VC shows valid downstream.
  assign in_ready  = out_ready & sel; // only the selected VC sees its ready upstream.

  //////////////////////////////
  // shared flit path
  //////////////////////////////

  always_comb begin
    int c;

    out_flit = '0; // quiet path if nothing is selected.
    out_last = 1'b0;
    for (c = 0; c < NUM_VC; c++) begin
      if (sel[c]) begin
        out_flit = in_flit[c]; // steer the selected VC's payload.
        out_last = in_last[c]; // and its last flag with it.
      end
    end
  end

  //////////////////////////////
  // arbitration
  //////////////////////////////

  noc_rr_arbiter i_arb (
    .req     (req),
    .gnt     (sel),
    .nxt_gnt (nxt_sel)
  );

  // the selection follows the arbiter on every edge.
  // flits of different VCs may therefore interleave cycle by cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      sel <= vc_mask_t'(1); // start out pointing at VC 0.
    end else begin
      sel <= nxt_sel; // take the next grant.
    end
  end

endmodule

`default_nettype wire

// ==== src/noc_rr_arbiter.sv ====
// Round-robin arbiter over the virtual channels.
// Purely combinational. It looks at the requests starting one channel past
// the current grant, wraps around, and returns the first requester as a
// one-hot next grant. Without any request the current grant stays.

`timescale 1ns/1ps
`default_nettype none

module noc_rr_arbiter import noc_vc_pkg::*; (
  input  vc_mask_t req,
  input  vc_mask_t gnt,
  output vc_mask_t nxt_gnt
);

  //////////////////////////////
  // next grant search
  //////////////////////////////

  always_comb begin
    int   cur; // index of the channel holding the current grant.
    int   idx; // channel examined at this step of the search.
    int   i;
    int   k;
    logic found; // set once a requester has been picked.

    cur     = 0; // a grant of zero is treated like VC 0.
    found   = 1'b0;
    nxt_gnt = gnt; // with no request the grant does not move.

    // turn the one-hot grant into an index.
    for (i = 0; i < NUM_VC; i++) begin
      if (gnt[i]) begin
        cur = i;
      end
    end

    // the current holder is looked at last, so a busy channel yields
    // to any other requester before it gets the path again.
    for (k = 1; k <= NUM_VC; k++) begin
      idx = (cur + k) % NUM_VC;
      if (!found && req[idx]) begin
        nxt_gnt      = '0; // clear the old grant.
        nxt_gnt[idx] = 1'b1; // first requester after the current one wins.
        found        = 1'b1; // later requesters are ignored.
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/noc_flit_fifo.sv ====
// Flit buffer for one virtual channel.
// Circular buffer of FIFO_DEPTH entries holding a flit and its last flag,
// with a valid/ready handshake on the push side and on the pop side.
// The head entry is shown on the pop side as soon as it is stored.

`timescale 1ns/1ps
`default_nettype none

module noc_flit_fifo import noc_vc_pkg::*; (
  input  wire   clk,
  input  wire   rst,

  input  flit_t push_flit,
  input  wire   push_last,
  input  wire   push_valid,
  output logic  push_ready,

  output flit_t pop_flit,
  output logic  pop_last,
  output logic  pop_valid,
  input  wire   pop_ready
);

  //////////////////////////////
  // storage and pointers
  //////////////////////////////

  flit_t              flit_mem [FIFO_DEPTH]; // payload storage for each entry.
  logic               last_mem [FIFO_DEPTH]; // last flag stored next to each flit.
  logic [FIFO_AW-1:0] wr_ptr; // next entry to write.
  logic [FIFO_AW-1:0] rd_ptr; // entry currently offered on the pop side.
  logic [FIFO_AW:0]   count; // number of stored flits, one bit wider than the pointers.

  logic push_fire; // a flit enters this cycle.
  logic pop_fire; // a flit leaves this cycle.

  //////////////////////////////
  // handshake
  //////////////////////////////

  assign push_ready = (count != (FIFO_AW+1)'(FIFO_DEPTH)); // room as long as not full.
  assign pop_valid  = (count != '0); // something to offer whenever not empty.

  assign push_fire = push_valid & push_ready; // transfer on the push side.
  assign pop_fire  = pop_valid & pop_ready; // transfer on the pop side.

  // the head entry drives the pop side directly.
  assign pop_flit = flit_mem[rd_ptr];
  assign pop_last = last_mem[rd_ptr];

  //////////////////////////////
  // write side
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (push_fire) begin
      flit_mem[wr_ptr] <= push_flit; // payload lands in the free slot.
      last_mem[wr_ptr] <= push_last; // its last flag goes along with it.
    end
  end

  //////////////////////////////
  // pointers and fill count
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0; // reset empties the buffer.
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, so the pointer wraps by itself.
      end
      if (pop_fire) begin
        rd_ptr <= rd_ptr + 1'b1; // move on to the next stored flit.
      end
      // a push and a pop in the same cycle leave the count unchanged.
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1; // one flit more.
        2'b01:   count <= count - 1'b1; // one flit less.
        default: count <= count; // idle or simultaneous push and pop.
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/noc_vc_pkg.sv ====
// Shared definitions for the two-channel virtual-channel link segment.
// Holds the link dimensions, the FIFO sizing and the vector types
// that carry flits and per-VC bit masks between the blocks.

`default_nettype none

package noc_vc_pkg;

  //////////////////////////////
  // link dimensions
  //////////////////////////////

  localparam int FLIT_W = 64; // payload bits in one flit.
  localparam int NUM_VC = 2; // virtual channels sharing the link.

  //////////////////////////////
  // per-VC buffering
  //////////////////////////////

  localparam int FIFO_DEPTH = 4; // entries in every VC FIFO, input and output side.
  localparam int FIFO_AW = 2; // pointer bits, log2 of FIFO_DEPTH.

  //////////////////////////////
  // vector types
  //////////////////////////////

  // one flit payload as it travels through buffers and the shared path.
  typedef logic [FLIT_W-1:0] flit_t;

  // one bit per virtual channel.
  // used for valid, ready, last, request and grant masks alike.
  typedef logic [NUM_VC-1:0] vc_mask_t;

endpackage

`default_nettype wire
